// ==== mul_unit.f ====
+incdir+dv
common/mul_pkg.sv
mul_shift/mul_shift_0term.sv
hdl/mul_op_decode.sv
hdl/mul_result_sel.sv
hdl/mul_unit.sv
dv/mul_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
TOP       ?= mul_unit_tb
FILELIST  ?= mul_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0 --timescale 1ns/1ps
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/mul_ref_model.svh ====
// reference model for the multiply unit, expected 64-bit result of one request

// sign or zero extension of a 64-bit operand to the full product width
function automatic logic [127:0] widen(input logic [63:0] v, input logic signed_op);
    return {{64{signed_op & v[63]}}, v};
endfunction

function automatic logic [63:0] mul_expect(input logic [2:0]  op,
                                           input logic        word,
                                           input logic [63:0] a,
                                           input logic [63:0] b);
    logic [127:0] wa;
    logic [127:0] wb;
    logic [127:0] prod;
    logic         a_signed;
    logic         b_signed;

    if (word) begin
        // MULW ignores funct3, low words signed
        wa   = widen({{32{a[31]}}, a[31:0]}, 1'b1);
        wb   = widen({{32{b[31]}}, b[31:0]}, 1'b1);
        prod = wa * wb;
        return {{32{prod[31]}}, prod[31:0]};
    end

    case (op)
        f3_mulhsu: begin
            a_signed = 1'b1;
            b_signed = 1'b0;
        end
        f3_mulhu: begin
            a_signed = 1'b0;
            b_signed = 1'b0;
        end
        default: begin
            a_signed = 1'b1;  // MUL and MULH
            b_signed = 1'b1;
        end
    endcase

    prod = widen(a, a_signed) * widen(b, b_signed);
    if (op == f3_mul) begin
        return prod[63:0];
    end
    return prod[127:64];
endfunction

// ==== dv/mul_unit_tb.sv ====
// testbench for the multiply unit that checks random requests, back-pressure and flush against a model
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb;
    import mul_pkg::*;

    `include "mul_ref_model.svh"

    localparam int num_random    = 400;
    localparam int num_short     = 60;
    localparam int num_flush     = 20;
    localparam int accept_limit  = 100;
    localparam int full_latency  = 66;
    localparam int short_latency = 20;
    localparam int drain_limit   = 400;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        in_valid;
    logic        word;
    logic [2:0]  op;
    logic [63:0] a;
    logic [63:0] b;
    logic        in_ready;
    logic        out_valid;
    logic [63:0] result;
    logic        out_ready;

    logic [63:0] expect_q[$];  // one entry at most
    int          error_count;
    int          n;
    logic [2:0]  op_pick;
    logic        word_pick;

    mul_unit uut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .word      (word),
        .op        (op),
        .a         (a),
        .b         (b),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .result    (result),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string what);
        error_count++;
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] exp,
                                   input logic [63:0] got);
        fail_now($sformatf("mismatch %s expected %016h actual %016h", test, exp, got));
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // corner values mixed in with plain random words
    function automatic logic [63:0] pick_operand();
        logic [63:0] v;
        case ($urandom % 8)
            0:       v = '0;
            1:       v = '1;
            2:       v = 64'h8000_0000_0000_0000;
            3:       v = {$urandom, 1'b1, 31'($urandom)};  // bit 31 set
            4:       v = 64'($urandom % 16);
            default: v = rand64();
        endcase
        return v;
    endfunction

    task automatic pick_op(output logic [2:0] op_o, output logic word_o);
        int kind;
        kind   = int'($urandom % 5);
        word_o = (kind == 4);
        op_o   = word_o ? 3'($urandom % 4) : 3'(kind);  // funct3 is don't care for MULW
    endtask

    task automatic accept_request(input string test, input logic [2:0] op_i,
                                  input logic word_i, input logic [63:0] a_i,
                                  input logic [63:0] b_i);
        int waited;
        waited = 0;
        @(negedge clk);
        op       = op_i;
        word     = word_i;
        a        = a_i;
        b        = b_i;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            assert (waited < accept_limit)
                else fail_now($sformatf("%s: timeout waiting for in_ready", test));
        end
        expect_q.push_back(mul_expect(op_i, word_i, a_i, b_i));
        @(negedge clk);  // taken on the edge just passed
        in_valid = 1'b0;
        op       = 3'($urandom % 8);
        word     = 1'($urandom % 2);
        a        = rand64();
        b        = rand64();
    endtask

    task automatic collect_result(input string test, input int max_latency);
        int          lat;
        logic        seen;
        logic        consumed;
        logic [63:0] held;
        logic [63:0] exp;
        lat      = 0;
        seen     = 1'b0;
        consumed = 1'b0;
        held     = '0;
        while (!consumed) begin
            assert (!in_ready)
                else fail_now($sformatf("%s: in_ready high before the result was taken",
                                        test));
            if (out_valid) begin
                if (!seen) begin
                    held = result;
                    seen = 1'b1;
                end
                assert (result === held) else report_mismatch({test, "_hold"}, held, result);
            end else begin
                assert (!seen)
                    else fail_now($sformatf("%s: result dropped before it was taken", test));
                assert (lat < max_latency)
                    else fail_now($sformatf("%s: no result within %0d cycles of accept",
                                            test, max_latency));
            end
            out_ready = ($urandom % 3) != 0;  // low about a third of the time
            if (out_valid && out_ready) begin
                exp = expect_q.pop_front();
                assert (result === exp) else report_mismatch(test, exp, result);
                consumed = 1'b1;
            end
            @(negedge clk);
            lat++;
            assert (lat < drain_limit)
                else fail_now($sformatf("%s: timeout waiting for the output handshake", test));
        end
        assert (!out_valid) else fail_now($sformatf("%s: result presented twice", test));
    endtask

    task automatic run_request(input string test, input logic [2:0] op_i, input logic word_i,
                               input logic [63:0] a_i, input logic [63:0] b_i,
                               input int max_latency);
        accept_request(test, op_i, word_i, a_i, b_i);
        collect_result(test, max_latency);
    endtask

    task automatic flush_request(input int delay);
        logic [63:0] b_long;
        b_long = rand64() | 64'h8000_0000_0000_0000;  // keeps the core busy all 64 steps
        accept_request("flush", f3_mulhu, 1'b0, rand64(), b_long);
        repeat (delay) begin
            assert (!out_valid) else fail_now("out_valid rose before the flush was raised");
            @(negedge clk);
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        expect_q.delete();  // cancelled request
        repeat (80) begin
            @(negedge clk);
            assert (!out_valid) else fail_now("out_valid rose for a flushed request");
        end
    endtask

    initial begin
        error_count = 0;
        void'($urandom(95));
        rst       = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        word      = 1'b0;
        op        = 3'd0;
        a         = '0;
        b         = '0;
        out_ready = 1'b0;

        repeat (4) begin
            @(negedge clk);
            assert (!out_valid && !in_ready)
                else fail_now("out_valid or in_ready high during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready) else fail_now("in_ready did not rise one cycle after reset");

        for (n = 0; n < num_random; n++) begin
            pick_op(op_pick, word_pick);
            run_request("random", op_pick, word_pick, pick_operand(), pick_operand(),
                        full_latency);
        end

        for (n = 0; n < num_short; n++) begin
            pick_op(op_pick, word_pick);
            run_request("early_term", op_pick, word_pick, pick_operand(),
                        64'($urandom % 16), short_latency);
        end

        for (n = 0; n < num_flush; n++) begin
            flush_request(1 + int'($urandom % 50));
            pick_op(op_pick, word_pick);
            run_request("after_flush", op_pick, word_pick, pick_operand(), pick_operand(),
                        full_latency);
        end

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
// multiply unit top: decode, shift-add core and result buffer
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  logic                     word,
    input  logic [2:0]               op,
    input  logic [mul_pkg::xlen-1:0] a,
    input  logic [mul_pkg::xlen-1:0] b,
    output logic                     in_ready,
    output logic                     out_valid,
    output logic [mul_pkg::xlen-1:0] result,
    input  logic                     out_ready
);
    import mul_pkg::*;

    logic            mul_valid;
    logic            mul_ready;
    logic            mulw;
    logic [1:0]      mul_signed;
    logic [xlen-1:0] multiplicand;
    logic [xlen-1:0] multiplier;
    logic            core_done;
    logic [xlen-1:0] result_hi;
    logic [xlen-1:0] result_lo;
    logic            sel_hi;
    logic            sel_word;
    logic            buf_free;

    mul_op_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_valid     (in_valid),
        .word         (word),
        .op           (op),
        .a            (a),
        .b            (b),
        .mul_ready    (mul_ready),
        .buf_free     (buf_free),
        .in_ready     (in_ready),
        .mul_valid    (mul_valid),
        .mulw         (mulw),
        .mul_signed   (mul_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .sel_hi       (sel_hi),
        .sel_word     (sel_word)
    );

    mul_shift_0term u_core (
        .clk          (clk),
        .rst          (rst),
        .mul_valid    (mul_valid),
        .flush        (flush),
        .mulw         (mulw),
        .mul_signed   (mul_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .mul_ready    (mul_ready),
        .out_valid    (core_done),
        .result_hi    (result_hi),
        .result_lo    (result_lo)
    );

    mul_result_sel u_result (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .core_done (core_done),
        .result_hi (result_hi),
        .result_lo (result_lo),
        .sel_hi    (sel_hi),
        .sel_word  (sel_word),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .result    (result),
        .buf_free  (buf_free)
    );

endmodule

`default_nettype wire

// ==== hdl/mul_result_sel.sv ====
// result stage: picks the product half and holds it in a one-entry output buffer
`timescale 1ns/1ps
`default_nettype none

module mul_result_sel (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     core_done,     // one-cycle pulse from core
    input  logic [mul_pkg::xlen-1:0] result_hi,
    input  logic [mul_pkg::xlen-1:0] result_lo,
    input  logic                     sel_hi,
    input  logic                     sel_word,
    input  logic                     out_ready,
    output logic                     out_valid,
    output logic [mul_pkg::xlen-1:0] result,
    output logic                     buf_free
);
    import mul_pkg::*;

    logic            full;
    logic [xlen-1:0] picked;
    logic [xlen-1:0] result_q;

    always_comb begin
        if (sel_word) begin
            picked = {{(xlen-32){result_lo[31]}}, result_lo[31:0]};  // MULW
        end else if (sel_hi) begin
            picked = result_hi;
        end else begin
            picked = result_lo;
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            full <= 1'b0;
        end else if (core_done) begin
            full <= 1'b1;  // decode only lets a request in with the buffer empty
        end else if (full && out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (core_done) begin
            result_q <= picked;
        end
    end

    assign out_valid = full;
    assign result    = result_q;
    assign buf_free  = ~full;

endmodule

`default_nettype wire

// ==== hdl/mul_op_decode.sv ====
// request decode: funct3 to signedness, handshake gating, result half selection
`timescale 1ns/1ps
`default_nettype none

module mul_op_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  logic                     word,
    input  logic [2:0]               op,
    input  logic [mul_pkg::xlen-1:0] a,
    input  logic [mul_pkg::xlen-1:0] b,
    input  logic                     mul_ready,
    input  logic                     buf_free,      // result buffer empty
    output logic                     in_ready,
    output logic                     mul_valid,
    output logic                     mulw,
    output logic [1:0]               mul_signed,
    output logic [mul_pkg::xlen-1:0] multiplicand,
    output logic [mul_pkg::xlen-1:0] multiplier,
    output logic                     sel_hi,        // high half wanted
    output logic                     sel_word       // sign-extend low word
);
    import mul_pkg::*;

    logic accept;

    // no new request while the result buffer is occupied or a flush is on
    assign mul_valid = in_valid & buf_free & ~flush;
    assign in_ready  = mul_ready & buf_free & ~flush;
    assign accept    = in_valid & in_ready;

    assign mulw         = word;
    assign multiplicand = a;
    assign multiplier   = b;

    always_comb begin
        if (word) begin
            mul_signed = sgn_ss;  // MULW regardless of funct3
        end else begin
            case (op)
                f3_mul:    mul_signed = sgn_ss;
                f3_mulh:   mul_signed = sgn_ss;
                f3_mulhsu: mul_signed = sgn_su;
                f3_mulhu:  mul_signed = sgn_uu;
                default:   mul_signed = sgn_ss;
            endcase
        end
    end

    // held until the next accept, result stage reads it on done
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_hi   <= 1'b0;
            sel_word <= 1'b0;
        end else if (accept) begin
            sel_hi   <= (op != f3_mul) && !word;
            sel_word <= word;
        end
    end

endmodule

`default_nettype wire

// ==== mul_shift/mul_shift_0term.sv ====
// iterative shift-add multiplier, one bit per cycle, stops once the multiplier runs out
`timescale 1ns/1ps
`default_nettype none

module mul_shift_0term (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mul_valid,
    input  logic                     flush,         // cancel in-flight op
    input  logic                     mulw,          // 32-bit word op
    input  logic [1:0]               mul_signed,
    input  logic [mul_pkg::xlen-1:0] multiplicand,
    input  logic [mul_pkg::xlen-1:0] multiplier,
    output logic                     mul_ready,
    output logic                     out_valid,     // one-cycle done pulse
    output logic [mul_pkg::xlen-1:0] result_hi,
    output logic [mul_pkg::xlen-1:0] result_lo
);
    import mul_pkg::*;

    localparam logic [6:0] last_step  = 7'd63;
    localparam logic [6:0] word_start = 7'd32;  // word ops only walk 32 bits
    localparam logic       st_idle    = 1'b0;
    localparam logic       st_mul     = 1'b1;

    logic                  state;
    logic [6:0]            step_cnt;
    logic [2*xlen-1:0]     mcand_q;     // shifted left each step
    logic [xlen-1:0]       mplier_q;    // shifted right each step
    logic                  mplier_neg;  // signed multiplier with sign bit set
    logic [2*xlen-1:0]     acc_q;

    logic                  a_signed;
    logic                  b_signed;
    logic [2*xlen-1:0]     mcand_ext;
    logic [xlen-1:0]       mplier_ext;
    logic [2*xlen-1:0]     addend;
    logic [2*xlen-1:0]     acc_next;
    logic                  accept;
    logic                  last;
    logic                  mplier_zero;
    logic                  finish;

    // ss and su both treat the multiplicand as signed, only ss the multiplier
    assign a_signed = (mul_signed != sgn_uu);
    assign b_signed = (mul_signed == sgn_ss);

    assign mcand_ext = mulw ?
        {{(2*xlen-32){a_signed & multiplicand[31]}}, multiplicand[31:0]} :
        {{xlen{a_signed & multiplicand[xlen-1]}}, multiplicand};
    assign mplier_ext = mulw ? {{(xlen-32){1'b0}}, multiplier[31:0]} : multiplier;

    assign accept      = mul_valid & mul_ready & (state == st_idle);
    assign last        = (step_cnt == last_step);
    assign mplier_zero = (mplier_q == '0);
    assign finish      = last | mplier_zero;

    assign addend = mplier_q[0] ? mcand_q : '0;

    // top multiplier bit carries weight -2^n when signed
    assign acc_next = (mplier_neg & last) ? (acc_q - addend) : (acc_q + addend);

    assign {result_hi, result_lo} = acc_q;

    // control
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state     <= st_idle;
            step_cnt  <= '0;
            mul_ready <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state     <= st_mul;
                        mul_ready <= 1'b0;
                        step_cnt  <= mulw ? word_start : 7'd0;
                    end else begin
                        mul_ready <= 1'b1;
                    end
                end
                st_mul: begin
                    step_cnt <= step_cnt + 7'd1;
                    if (finish) begin
                        state     <= st_idle;
                        out_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_q      <= '0;
            mcand_q    <= mcand_ext;
            mplier_q   <= mplier_ext;
            mplier_neg <= b_signed & (mulw ? multiplier[31] : multiplier[xlen-1]);
        end else if (state == st_mul) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== common/mul_pkg.sv ====
// multiply unit package: funct3 codes, signedness codes and data width
`default_nettype none

package mul_pkg;

    // datapath width, the core's product and counter are sized around it
    parameter int xlen = 64;

    // funct3 codes of the M extension multiply group
    parameter logic [2:0] f3_mul    = 3'd0;  // low half
    parameter logic [2:0] f3_mulh   = 3'd1;  // high half, signed x signed
    parameter logic [2:0] f3_mulhsu = 3'd2;  // high half, signed x unsigned
    parameter logic [2:0] f3_mulhu  = 3'd3;  // high half, unsigned x unsigned

    // signedness codes for the shift core
    // bit 1 marks the multiplicand signed, bit 0 the multiplier
    parameter logic [1:0] sgn_ss = 2'b11;
    parameter logic [1:0] sgn_su = 2'b10;
    parameter logic [1:0] sgn_uu = 2'b00;

endpackage

`default_nettype wire
